//--- src.f
src/dcache_pkg.sv
src/bank_ram.sv
src/data_store.sv
src/tag_store.sv
src/victim_buffer.sv
src/cache_ctrl.sv
src/dcache_top.sv
verif/axi_mem_model.sv
verif/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/bank_ram.sv
  - src/data_store.sv
  - src/tag_store.sv
  - src/victim_buffer.sv
  - src/cache_ctrl.sv
  - src/dcache_top.sv
  - target: test
    files:
      - verif/axi_mem_model.sv
      - verif/tb_dcache.sv

//--- verif/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*;
();

	localparam int CLK_PERIOD  = 40;
	localparam int NUM_REQS    = 20;
	localparam int WATCHDOG_NS = NUM_REQS * 80 * CLK_PERIOD;
	localparam int MEM_WORDS   = 65536;

	logic       clk;
	logic       rst;
	logic       data_req;
	logic       data_wr;
	logic [3:0] req_id;
	addr_t      data_addr;
	word_t      data_wdata;
	strb_t      data_wstrb;
	logic       data_addr_ok;
	logic       data_data_ok;
	word_t      data_rdata;
	logic [3:0] data_id;
	addr_t      araddr;
	logic       arvalid, arready;
	word_t      rdata;
	logic       rvalid, rlast, rready;
	addr_t      awaddr;
	logic       awvalid, awready;
	word_t      wdata;
	logic       wvalid, wlast, wready;
	logic       bvalid, bready;
	int         ar_count, aw_count, r_count, b_count;
	addr_t      last_araddr, last_awaddr;
	line_t      last_wline;

	// expected memory image updated on every store
	word_t      shadow [MEM_WORDS];
	int         errors;
	int         checks;
	logic [3:0] next_id;

	dcache_top DUT (.*);

	axi_mem_model u_mem (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: DUT did not finish within %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic check_eq(input word_t got, input word_t exp, input string what);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// issues one request and returns its load data and latency in cycles
	task automatic cpu_access(input logic wr, input addr_t addr, input word_t wdata_in,
		input strb_t strb, output word_t rdata_out, output int lat);
		logic [3:0] id;
		id = next_id;
		next_id = next_id + 4'd1;
		@(posedge clk);
		data_req   <= 1'b1;
		data_wr    <= wr;
		req_id     <= id;
		data_addr  <= addr;
		data_wdata <= wdata_in;
		data_wstrb <= strb;
		@(negedge clk);
		while (!data_addr_ok)
			@(negedge clk);
		@(posedge clk);
		data_req   <= 1'b0;
		// request fields change once accepted so only captured values count
		req_id     <= ~id;
		data_addr  <= ~addr;
		data_wdata <= ~wdata_in;
		data_wstrb <= ~strb;
		lat = 0;
		do
		begin
			@(negedge clk);
			lat++;
		end
		while (!data_data_ok);
		rdata_out = data_rdata;
		check_eq(word_t'(data_id), word_t'(id), "data_id");
	endtask

	task automatic read_check(input addr_t addr, input logic expect_hit);
		word_t got;
		int    lat;
		cpu_access(1'b0, addr, '0, '0, got, lat);
		check_eq(got, shadow[addr[17:2]], $sformatf("read of %h", addr));
		if (expect_hit)
			check_eq(word_t'(lat), 32'd1, $sformatf("hit latency at %h", addr));
	endtask

	task automatic write_word(input addr_t addr, input word_t data, input strb_t strb,
		input logic expect_hit);
		word_t unused;
		int    lat;
		for (int i = 0; i < 4; i++)
		begin
			if (strb[i])
				shadow[addr[17:2]][8*i +: 8] = data[8*i +: 8];
		end
		cpu_access(1'b1, addr, data, strb, unused, lat);
		if (expect_hit)
			check_eq(word_t'(lat), 32'd1, $sformatf("write hit latency at %h", addr));
	endtask

	task automatic wait_writeback(input int target);
		while (b_count < target)
			@(negedge clk);
	endtask

	task automatic idle_after_reset();
		check_eq(word_t'({data_data_ok, arvalid, rready, awvalid, wvalid, bready}), '0,
			"handshake outputs after reset");
	endtask

	task automatic miss_then_hit_read();
		int ar0;
		int r0;
		ar0 = ar_count;
		r0  = r_count;
		read_check(32'h0000_0124, 1'b0);
		check_eq(ar_count - ar0, 1, "AR count on read miss");
		check_eq(last_araddr, 32'h0000_0120, "AR address");
		check_eq(r_count - r0, 8, "read beats on refill");
		// other word of the same line
		read_check(32'h0000_012c, 1'b1);
		check_eq(ar_count - ar0, 1, "AR count after hit");
	endtask

	task automatic strobed_write_readback();
		write_word(32'h0000_0124, 32'haabb_ccdd, 4'b0101, 1'b1);
		read_check(32'h0000_0124, 1'b1);
		// write miss allocates the line first
		write_word(32'h0000_1144, 32'h1122_3344, 4'b1000, 1'b0);
		read_check(32'h0000_1144, 1'b1);
	endtask

	task automatic dirty_line_write_back();
		int aw0;
		int b0;
		write_word(32'h0000_2284, 32'hdead_beef, 4'hf, 1'b0);
		write_word(32'h0000_3288, 32'hcafe_f00d, 4'hf, 1'b0);
		aw0 = aw_count;
		b0  = b_count;
		// third tag in set 20 pushes out the older dirty line
		read_check(32'h0000_4280, 1'b0);
		wait_writeback(b0 + 1);
		check_eq(aw_count - aw0, 1, "AW count on dirty eviction");
		check_eq(last_awaddr, 32'h0000_2280, "AW address");
		for (int i = 0; i < WORDS_PER_LINE; i++)
			check_eq(last_wline[i], shadow[16'h08a0 + i], $sformatf("write-back word %0d", i));
		read_check(32'h0000_2284, 1'b0);
		wait_writeback(b0 + 2);
	endtask

	task automatic lru_victim_choice();
		int ar0;
		int aw0;
		ar0 = ar_count;
		aw0 = aw_count;
		read_check(32'h0000_5500, 1'b0);
		read_check(32'h0000_6500, 1'b0);
		read_check(32'h0000_5504, 1'b1);
		read_check(32'h0000_7500, 1'b0);
		check_eq(ar_count - ar0, 3, "AR count after three misses");
		read_check(32'h0000_5508, 1'b1);
		check_eq(ar_count - ar0, 3, "AR count after re-reading recent line");
		read_check(32'h0000_650c, 1'b0);
		check_eq(ar_count - ar0, 4, "AR count after re-reading evicted line");
		check_eq(aw_count - aw0, 0, "AW count with clean lines");
	endtask

	// refill of a line that may still sit in the victim buffer
	task automatic hazard_refill();
		write_word(32'h0000_8640, 32'h0bad_f00d, 4'hf, 1'b0);
		read_check(32'h0000_9640, 1'b0);
		read_check(32'h0000_a640, 1'b0);
		read_check(32'h0000_8640, 1'b0);
	endtask

	initial
	begin
		errors     = 0;
		checks     = 0;
		next_id    = 4'd1;
		rst        = 1'b1;
		data_req   = 1'b0;
		data_wr    = 1'b0;
		req_id     = '0;
		data_addr  = '0;
		data_wdata = '0;
		data_wstrb = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			shadow[i] = ~word_t'(i);
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		idle_after_reset();
		miss_then_hit_read();
		strobed_write_readback();
		dirty_line_write_back();
		lru_victim_choice();
		hazard_refill();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import dcache_pkg::*;
(
	input  wire   clk,
	input  wire   rst,
	input  addr_t araddr,
	input  wire   arvalid,
	output logic  arready,
	output word_t rdata,
	output logic  rvalid,
	output logic  rlast,
	input  wire   rready,
	input  addr_t awaddr,
	input  wire   awvalid,
	output logic  awready,
	input  word_t wdata,
	input  wire   wvalid,
	input  wire   wlast,
	output logic  wready,
	output logic  bvalid,
	input  wire   bready,
	// bookkeeping seen by the testbench
	output int    ar_count,
	output int    aw_count,
	output int    r_count,
	output int    b_count,
	output addr_t last_araddr,
	output addr_t last_awaddr,
	output line_t last_wline
);

	localparam int MEM_WORDS = 65536;

	word_t       mem [MEM_WORDS];
	logic [15:0] rd_ptr;
	logic [15:0] wr_ptr;
	word_sel_t   r_beat;
	word_sel_t   w_beat;
	logic        rd_active;
	logic        wr_active;
	logic        b_pend;
	int          ar_wait;
	int          r_wait;
	int          aw_wait;
	int          w_wait;
	int          b_wait;

	// 0 to 3 idle cycles before a ready or valid
	function automatic int rand_delay();
		return int'($urandom % 4);
	endfunction

	initial
	begin
		// one seed for the whole run
		ar_wait = int'($urandom(32'h4caa_1c7f) % 4);
		r_wait  = 0;
		aw_wait = 0;
		w_wait  = 0;
		b_wait  = 0;
		// each word starts as its inverted word address
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = ~word_t'(i);
		{arready, rvalid, rlast, awready, wready, bvalid} = '0;
		{rd_active, wr_active, b_pend} = '0;
		rdata = '0;
		{ar_count, aw_count, r_count, b_count} = '0;
		forever
		begin
			@(posedge clk);
			if (rst)
			begin
				{arready, rvalid, rlast, awready, wready, bvalid} <= '0;
				{rd_active, wr_active, b_pend} <= '0;
				{ar_count, aw_count, r_count, b_count} <= '0;
			end
			else
			begin
				// read address
				arready <= 1'b0;
				if (arvalid && !arready && !rd_active)
				begin
					if (ar_wait == 0)
						arready <= 1'b1;
					else
						ar_wait <= ar_wait - 1;
				end
				if (arvalid && arready)
				begin
					rd_active   <= 1'b1;
					rd_ptr      <= araddr[17:2];
					r_beat      <= '0;
					ar_count    <= ar_count + 1;
					last_araddr <= araddr;
					ar_wait     <= rand_delay();
				end
				// read data, eight beats
				if (rvalid && rready)
				begin
					rvalid  <= 1'b0;
					rlast   <= 1'b0;
					r_count <= r_count + 1;
					rd_ptr  <= rd_ptr + 1'b1;
					r_beat  <= r_beat + 1'b1;
					r_wait  <= rand_delay();
					if (rlast)
						rd_active <= 1'b0;
				end
				else if (rd_active && !rvalid)
				begin
					if (r_wait == 0)
					begin
						rvalid <= 1'b1;
						rdata  <= mem[rd_ptr];
						rlast  <= (r_beat == 3'd7);
					end
					else
						r_wait <= r_wait - 1;
				end
				// write address
				awready <= 1'b0;
				if (awvalid && !awready && !wr_active)
				begin
					if (aw_wait == 0)
						awready <= 1'b1;
					else
						aw_wait <= aw_wait - 1;
				end
				if (awvalid && awready)
				begin
					wr_active   <= 1'b1;
					wr_ptr      <= awaddr[17:2];
					w_beat      <= '0;
					aw_count    <= aw_count + 1;
					last_awaddr <= awaddr;
					aw_wait     <= rand_delay();
				end
				// write data
				wready <= 1'b0;
				if (wr_active && wvalid && !wready)
				begin
					if (w_wait == 0)
						wready <= 1'b1;
					else
						w_wait <= w_wait - 1;
				end
				if (wvalid && wready)
				begin
					mem[wr_ptr]        <= wdata;
					last_wline[w_beat] <= wdata;
					wr_ptr             <= wr_ptr + 1'b1;
					w_beat             <= w_beat + 1'b1;
					w_wait             <= rand_delay();
					if (wlast)
					begin
						wr_active <= 1'b0;
						b_pend    <= 1'b1;
					end
				end
				// write response
				if (bvalid && bready)
				begin
					bvalid  <= 1'b0;
					b_count <= b_count + 1;
				end
				else if (b_pend && !bvalid)
				begin
					if (b_wait == 0)
					begin
						bvalid <= 1'b1;
						b_pend <= 1'b0;
						b_wait <= rand_delay();
					end
					else
						b_wait <= b_wait - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	// cpu data port
	input  wire        data_req,
	input  wire        data_wr,
	input  wire  [3:0] req_id,
	input  addr_t      data_addr,
	input  word_t      data_wdata,
	input  strb_t      data_wstrb,
	output logic       data_addr_ok,
	output logic       data_data_ok,
	output word_t      data_rdata,
	output logic [3:0] data_id,
	// axi read
	output addr_t      araddr,
	output logic       arvalid,
	input  wire        arready,
	input  word_t      rdata,
	input  wire        rvalid,
	input  wire        rlast,
	output logic       rready,
	// axi write
	output addr_t      awaddr,
	output logic       awvalid,
	input  wire        awready,
	output word_t      wdata,
	output logic       wvalid,
	output logic       wlast,
	input  wire        wready,
	input  wire        bvalid,
	output logic       bready
);

	index_t     ram_index;
	tag_t       cmp_tag;
	word_sel_t  word_sel;
	way_vec_t   hit_way;
	logic       victim_way;
	logic       victim_dirty;
	tag_t       victim_tag;
	logic       lookup_hit;
	logic       store_en;
	strb_t      store_strb;
	word_t      store_data;
	logic       fill_en;
	word_sel_t  fill_word;
	logic       fill_done;
	tag_t       fill_tag;
	logic       fill_dirty;
	logic       capture;
	line_addr_t req_line;
	logic       busy;
	logic       line_hazard;
	line_t      victim_line;

	cache_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.data_req     (data_req),
		.data_wr      (data_wr),
		.req_id       (req_id),
		.data_addr    (data_addr),
		.data_wdata   (data_wdata),
		.data_wstrb   (data_wstrb),
		.data_addr_ok (data_addr_ok),
		.data_data_ok (data_data_ok),
		.data_id      (data_id),
		.hit_way      (hit_way),
		.victim_dirty (victim_dirty),
		.busy         (busy),
		.line_hazard  (line_hazard),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rvalid       (rvalid),
		.rlast        (rlast),
		.rready       (rready),
		.ram_index    (ram_index),
		.cmp_tag      (cmp_tag),
		.word_sel     (word_sel),
		.lookup_hit   (lookup_hit),
		.store_en     (store_en),
		.store_strb   (store_strb),
		.store_data   (store_data),
		.fill_en      (fill_en),
		.fill_word    (fill_word),
		.fill_done    (fill_done),
		.fill_tag     (fill_tag),
		.fill_dirty   (fill_dirty),
		.capture      (capture),
		.req_line     (req_line)
	);

	tag_store u_tags (
		.clk          (clk),
		.rst          (rst),
		.ram_index    (ram_index),
		.cmp_tag      (cmp_tag),
		.lookup_hit   (lookup_hit),
		.store_en     (store_en),
		.fill_done    (fill_done),
		.fill_tag     (fill_tag),
		.fill_dirty   (fill_dirty),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	// load word goes straight out to the cpu
	data_store u_data (
		.clk         (clk),
		.ram_index   (ram_index),
		.word_sel    (word_sel),
		.hit_way     (hit_way),
		.victim_way  (victim_way),
		.store_en    (store_en),
		.store_strb  (store_strb),
		.store_data  (store_data),
		.fill_en     (fill_en),
		.fill_word   (fill_word),
		.fill_data   (rdata),
		.load_data   (data_rdata),
		.victim_line (victim_line)
	);

	victim_buffer u_victim (
		.clk         (clk),
		.rst         (rst),
		.capture     (capture),
		.victim_tag  (victim_tag),
		.ram_index   (ram_index),
		.victim_line (victim_line),
		.req_line    (req_line),
		.busy        (busy),
		.line_hazard (line_hazard),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wvalid      (wvalid),
		.wlast       (wlast),
		.wready      (wready),
		.bvalid      (bvalid),
		.bready      (bready)
	);

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import dcache_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	// cpu side
	input  wire        data_req,
	input  wire        data_wr,
	input  wire  [3:0] req_id,
	input  addr_t      data_addr,
	input  word_t      data_wdata,
	input  strb_t      data_wstrb,
	output logic       data_addr_ok,
	output logic       data_data_ok,
	output logic [3:0] data_id,
	// tag store and victim buffer status
	input  way_vec_t   hit_way,
	input  wire        victim_dirty,
	input  wire        busy,
	input  wire        line_hazard,
	// axi read channel
	output addr_t      araddr,
	output logic       arvalid,
	input  wire        arready,
	input  wire        rvalid,
	input  wire        rlast,
	output logic       rready,
	// array commands
	output index_t     ram_index,
	output tag_t       cmp_tag,
	output word_sel_t  word_sel,
	output logic       lookup_hit,
	output logic       store_en,
	output strb_t      store_strb,
	output word_t      store_data,
	output logic       fill_en,
	output word_sel_t  fill_word,
	output logic       fill_done,
	output tag_t       fill_tag,
	output logic       fill_dirty,
	output logic       capture,
	output line_addr_t req_line
);

	typedef enum logic [2:0] {
		S_IDLE, S_LOOKUP, S_EVICT, S_REQ_LINE, S_REFILL, S_REPLAY
	} state_t;

	state_t     state;
	word_sel_t  fill_cnt;
	logic       hit;
	logic       accept;

	// captured request
	logic       wr_q;
	addr_t      addr_q;
	word_t      wdata_q;
	strb_t      wstrb_q;
	logic [3:0] id_q;

	assign hit = |hit_way;

	// a read hit frees the pipeline for the next request in the same cycle
	assign data_addr_ok = data_req &&
		(state == S_IDLE || (state == S_LOOKUP && !wr_q && hit));
	assign accept = data_addr_ok;

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wr_q    <= data_wr;
			addr_q  <= data_addr;
			wdata_q <= data_wdata;
			wstrb_q <= data_wstrb;
			id_q    <= req_id;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= S_IDLE;
			fill_cnt <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (accept)
						state <= S_LOOKUP;
				S_LOOKUP:
					if (hit)
						state <= accept ? S_LOOKUP : S_IDLE;
					else if (victim_dirty)
						state <= S_EVICT;
					else
						state <= S_REQ_LINE;
				S_EVICT:
					if (!busy)
						state <= S_REQ_LINE;
				S_REQ_LINE:
					if (arvalid && arready)
						state <= S_REFILL;
				S_REFILL:
					if (rvalid)
					begin
						fill_cnt <= fill_cnt + 1'b1;
						if (rlast)
							state <= S_REPLAY;
					end
				default:
					state <= S_LOOKUP;
			endcase
		end
	end

	// banks and tags follow the live address only when a request enters
	assign ram_index = (state == S_IDLE || accept) ? data_addr[11:5] : addr_q[11:5];
	assign cmp_tag   = addr_q[31:12];
	assign word_sel  = addr_q[4:2];

	assign lookup_hit   = (state == S_LOOKUP) && hit;
	assign store_en     = lookup_hit && wr_q;
	assign store_strb   = wstrb_q;
	assign store_data   = wdata_q;
	assign data_data_ok = lookup_hit;
	assign data_id      = id_q;

	assign capture  = (state == S_EVICT) && !busy;
	assign req_line = addr_q[31:5];

	assign araddr  = {addr_q[31:5], 5'b0};
	assign arvalid = (state == S_REQ_LINE) && !line_hazard;
	assign rready  = (state == S_REFILL);

	assign fill_en    = rready && rvalid;
	assign fill_word  = fill_cnt;
	assign fill_done  = fill_en && rlast;
	assign fill_tag   = addr_q[31:12];
	assign fill_dirty = wr_q;

endmodule

`default_nettype wire

//--- src/victim_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module victim_buffer import dcache_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	input  wire        capture,
	input  tag_t       victim_tag,
	input  index_t     ram_index,
	input  line_t      victim_line,
	input  line_addr_t req_line,
	output logic       busy,
	output logic       line_hazard,
	output addr_t      awaddr,
	output logic       awvalid,
	input  wire        awready,
	output word_t      wdata,
	output logic       wvalid,
	output logic       wlast,
	input  wire        wready,
	input  wire        bvalid,
	output logic       bready
);

	typedef enum logic [1:0] {VB_IDLE, VB_ADDR, VB_DATA, VB_RESP} vb_state_t;

	vb_state_t  state;
	word_sel_t  beat;
	line_t      line_q;
	line_addr_t line_addr_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= VB_IDLE;
			beat  <= '0;
		end
		else
		begin
			case (state)
				VB_IDLE:
					if (capture)
						state <= VB_ADDR;
				VB_ADDR:
					if (awready)
						state <= VB_DATA;
				VB_DATA:
					if (wready)
					begin
						beat <= beat + 1'b1;
						if (wlast)
							state <= VB_RESP;
					end
				default:
					if (bvalid)
						state <= VB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			line_q      <= victim_line;
			line_addr_q <= {victim_tag, ram_index};
		end
	end

	assign busy        = (state != VB_IDLE);
	// refill of the held line must wait until it reaches memory
	assign line_hazard = busy && (req_line == line_addr_q);

	assign awaddr  = {line_addr_q, 5'b0};
	assign awvalid = (state == VB_ADDR);
	assign wdata   = line_q[beat];
	assign wvalid  = (state == VB_DATA);
	assign wlast   = wvalid && (beat == word_sel_t'(WORDS_PER_LINE - 1));
	assign bready  = (state == VB_RESP);

endmodule

`default_nettype wire

//--- src/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store import dcache_pkg::*;
(
	input  wire      clk,
	input  wire      rst,
	input  index_t   ram_index,
	input  tag_t     cmp_tag,
	input  wire      lookup_hit,
	input  wire      store_en,
	input  wire      fill_done,
	input  tag_t     fill_tag,
	input  wire      fill_dirty,
	output way_vec_t hit_way,
	output logic     victim_way,
	output logic     victim_dirty,
	output tag_t     victim_tag
);

	tag_t                tag_mem [2][NUM_SETS];
	logic [NUM_SETS-1:0] valid_q [2];
	logic [NUM_SETS-1:0] dirty_q [2];
	// way used most recently, per set
	logic [NUM_SETS-1:0] lru_q;
	index_t              rd_index;
	way_vec_t            valid_set;

	// set index lags one cycle, lining up with the data banks
	always_ff @(posedge clk)
	begin
		rd_index <= ram_index;
		if (fill_done)
			tag_mem[victim_way][rd_index] <= fill_tag;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_q[0] <= '0;
			valid_q[1] <= '0;
			dirty_q[0] <= '0;
			dirty_q[1] <= '0;
			lru_q      <= '0;
		end
		else
		begin
			if (lookup_hit)
				lru_q[rd_index] <= hit_way[1];
			for (int w = 0; w < 2; w++)
			begin
				if (store_en && hit_way[w])
					dirty_q[w][rd_index] <= 1'b1;
			end
			if (fill_done)
			begin
				valid_q[victim_way][rd_index] <= 1'b1;
				dirty_q[victim_way][rd_index] <= fill_dirty;
			end
		end
	end

	always_comb
	begin
		for (int w = 0; w < 2; w++)
		begin
			valid_set[w] = valid_q[w][rd_index];
			hit_way[w]   = valid_set[w] && (tag_mem[w][rd_index] == cmp_tag);
		end
		// invalid ways first, then the one not touched last
		if (!valid_set[0])
			victim_way = 1'b0;
		else if (!valid_set[1])
			victim_way = 1'b1;
		else
			victim_way = !lru_q[rd_index];
		victim_dirty = valid_set[victim_way] && dirty_q[victim_way][rd_index];
		victim_tag   = tag_mem[victim_way][rd_index];
	end

endmodule

`default_nettype wire

//--- src/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store import dcache_pkg::*;
(
	input  wire       clk,
	input  index_t    ram_index,
	input  word_sel_t word_sel,
	input  way_vec_t  hit_way,
	input  wire       victim_way,
	input  wire       store_en,
	input  strb_t     store_strb,
	input  word_t     store_data,
	input  wire       fill_en,
	input  word_sel_t fill_word,
	input  word_t     fill_data,
	output word_t     load_data,
	output line_t     victim_line
);

	word_t rd [2][WORDS_PER_LINE];
	word_t bank_wdata;

	// only one of store and fill is active in a cycle
	assign bank_wdata = fill_en ? fill_data : store_data;

	for (genvar w = 0; w < 2; w++)
	begin : g_way
		for (genvar b = 0; b < WORDS_PER_LINE; b++)
		begin : g_bank
			strb_t we;

			always_comb
			begin
				we = '0;
				if (store_en && hit_way[w] && word_sel == word_sel_t'(b))
					we = store_strb;
				else if (fill_en && victim_way == w && fill_word == word_sel_t'(b))
					we = 4'hf;
			end

			bank_ram u_bank (
				.clk   (clk),
				.index (ram_index),
				.we    (we),
				.wdata (bank_wdata),
				.rdata (rd[w][b])
			);
		end
	end

	assign load_data = hit_way[1] ? rd[1][word_sel] : rd[0][word_sel];

	// whole victim-way line, taken by the victim buffer on eviction
	always_comb
	begin
		for (int i = 0; i < WORDS_PER_LINE; i++)
			victim_line[i] = rd[victim_way][i];
	end

endmodule

`default_nettype wire

//--- src/bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bank_ram import dcache_pkg::*;
(
	input  wire   clk,
	input  index_t index,
	input  strb_t  we,
	input  word_t  wdata,
	output word_t  rdata
);

	word_t mem [NUM_SETS];

	// byte lanes written separately, read returns the old word
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (we[i])
				mem[index][8*i +: 8] <= wdata[8*i +: 8];
		end
		rdata <= mem[index];
	end

endmodule

`default_nettype wire

//--- src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// 128 sets of 32-byte lines, two ways
	localparam int INDEX_W        = 7;
	localparam int TAG_W          = 20;
	localparam int WORD_SEL_W     = 3;
	localparam int WORDS_PER_LINE = 8;
	localparam int NUM_SETS       = 128;

	typedef logic [31:0]                addr_t;
	typedef logic [31:0]                word_t;
	typedef logic [3:0]                 strb_t;
	typedef logic [INDEX_W-1:0]         index_t;
	typedef logic [TAG_W-1:0]           tag_t;
	typedef logic [WORD_SEL_W-1:0]      word_sel_t;
	// tag followed by index
	typedef logic [TAG_W+INDEX_W-1:0]   line_addr_t;
	typedef logic [1:0]                 way_vec_t;
	typedef word_t [WORDS_PER_LINE-1:0] line_t;

endpackage

`default_nettype wire
